//--- design/proto_pkg.sv
// Host word formats. Little-endian bit numbering, only LOOP and CMD words are acted on
package proto_pkg;

    localparam logic [7:0] HOST_MAGIC = 8'h77;  // Bits 7:0 of every accepted word

    // Type field in bits 9:8
    typedef enum logic [1:0] {
        RX_TLP  = 2'b00,  // Dropped here
        RX_CFG  = 2'b01,  // Dropped here
        RX_LOOP = 2'b10,
        RX_CMD  = 2'b11
    } rx_type_t;

    // Output stream tag
    typedef enum logic [1:0] {
        TAG_LOOP = 2'b10,
        TAG_RESP = 2'b11
    } tx_tag_t;

    // ----------------------------------------------------------
    // Incoming 64-bit word, two decodings of the same bits
    // ----------------------------------------------------------
    typedef struct packed {
        logic [31:0] payload;   // 63:32
        logic [19:0] rsvd;      // 31:12
        logic [1:0]  ctx;       // 11:10 returned with the payload
        rx_type_t    rtype;     // 9:8
        logic [7:0]  magic;     // 7:0
    } rx_loop_t;

    typedef struct packed {
        logic [15:0] value;     // 63:48 byte-swapped
        logic [15:0] mask;      // 47:32 byte-swapped
        logic [15:0] addr;      // 31:16 byte address, MSB picks RW bank
        logic [1:0]  rsvd_hi;   // 15:14
        logic        wr;        // 13
        logic        rd;        // 12
        logic [1:0]  rsvd_lo;   // 11:10
        rx_type_t    rtype;     // 9:8
        logic [7:0]  magic;     // 7:0
    } rx_cmd_t;

    typedef union packed {
        rx_loop_t loop;
        rx_cmd_t  cmd;
    } rx_word_u;

    // Buffer entry
    typedef struct packed {
        logic [1:0]  ctx;
        logic [31:0] data;
    } fifo_entry_t;

endpackage

//--- design/regmap_pkg.sv
// Register map and buffer sizing. Banks are byte addressed and reads are 16 bits wide
package regmap_pkg;

    // ----------------------------------------------------------
    // Bank geometry
    // ----------------------------------------------------------
    localparam int unsigned RO_BYTES = 16;
    localparam int unsigned RW_BYTES = 8;
    localparam int unsigned RO_AW    = $clog2(RO_BYTES);  // Byte offset bits inside RO
    localparam int unsigned RW_AW    = $clog2(RW_BYTES);  // Byte offset bits inside RW

    // Identity
    localparam logic [15:0] RO_MAGIC      = 16'hab89;
    localparam logic [15:0] RW_MAGIC      = 16'hefcd;
    localparam logic [7:0]  VERSION_MAJOR = 8'h01;
    localparam logic [7:0]  VERSION_MINOR = 8'h02;
    localparam logic [7:0]  DEVICE_ID     = 8'h05;
    localparam logic [31:0] CUSTOM_VALUE  = 32'hc0ffee01;

    // RW byte addresses
    localparam int unsigned RW_ADDR_CTRL    = 2;
    localparam int unsigned RW_ADDR_COUNT   = 4;
    localparam int unsigned RW_ADDR_SCRATCH = 6;
    localparam int unsigned CTRL_SEND_EN    = 0;  // Bit in CTRL

    localparam logic [15:0] COUNT_TAG_ADDR = 16'hfffe;  // Address field of a count word

    // Read-only image, byte 0 in the low bits
    localparam logic [RO_BYTES*8-1:0] RO_IMAGE = {
        CUSTOM_VALUE,                                   // +C
        8'h00, DEVICE_ID,                               // +A
        VERSION_MINOR, VERSION_MAJOR,                   // +8
        32'(RO_BYTES),                                  // +4
        16'h0000,                                       // +2
        RO_MAGIC                                        // +0
    };

    // Read-write reset image
    localparam logic [RW_BYTES*8-1:0] RW_RESET = {
        16'h0000,                                       // +6 scratch
        16'h0000,                                       // +4 send count
        16'h0000,                                       // +2 control flags
        RW_MAGIC                                        // +0
    };

    // Buffers
    localparam int unsigned FIFO_DEPTH = 16;
    localparam int unsigned FIFO_AFULL = 12;
    localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

//--- design/fifo_if.sv
// One buffer's write and read sides. Read side is show-ahead, full writes are dropped
`timescale 1ns/100ps

interface fifo_if
    import proto_pkg::*;
();

    // Write side
    logic        wr_en;         // Store on every clock it is high
    fifo_entry_t wr_data;
    logic        almost_full;   // Level flag for the producer

    // Read side
    logic        rd_en;         // Pops the entry shown this cycle
    fifo_entry_t rd_data;       // Oldest entry while rd_valid
    logic        rd_valid;

    modport producer (
        output wr_en, wr_data,
        input  almost_full
    );

    modport buffer (
        input  wr_en, wr_data, rd_en,
        output almost_full, rd_data, rd_valid
    );

    modport consumer (
        input  rd_data, rd_valid,
        output rd_en
    );

endinterface

//--- design/cmd_engine.sv
// Commands run as they arrive with no input buffering. Responses are lost if resp_q is full
`timescale 1ns/100ps

module cmd_engine
    import proto_pkg::*;
    import regmap_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  rx_word_u i_rx_data,
    input  logic     i_rx_valid,
    fifo_if.producer loop_q,
    fifo_if.producer resp_q
);

    // ----------------------------------------------------------
    // Routing
    // ----------------------------------------------------------
    logic        magic_ok;
    logic        is_loop;
    logic        is_cmd;

    assign magic_ok = i_rx_valid && (i_rx_data.loop.magic == HOST_MAGIC);
    assign is_loop  = magic_ok && (i_rx_data.loop.rtype == RX_LOOP);
    assign is_cmd   = magic_ok && (i_rx_data.cmd.rtype == RX_CMD);  // TLP and CFG fall out

    // ----------------------------------------------------------
    // Command decode
    // ----------------------------------------------------------
    logic [RW_BYTES*8-1:0] rw_q;        // RW bank contents
    logic [15:0]           cmd_addr;
    logic [14:0]           byte_off;
    logic                  bank_rw;
    logic [15:0]           cmd_value;
    logic [15:0]           cmd_mask;
    logic                  ro_hit;
    logic                  rw_hit;
    logic [RO_AW+2:0]      ro_bit;      // Bit offset into RO image
    logic [RW_AW+2:0]      rw_bit;      // Bit offset into RW bank
    logic [15:0]           rd_word;
    logic [15:0]           rw_old;
    logic [15:0]           rw_new;
    logic                  do_read;
    logic                  do_write;

    assign cmd_addr  = i_rx_data.cmd.addr;
    assign bank_rw   = cmd_addr[15];
    assign byte_off  = cmd_addr[14:0];
    assign cmd_value = {i_rx_data.cmd.value[7:0], i_rx_data.cmd.value[15:8]};  // Host order
    assign cmd_mask  = {i_rx_data.cmd.mask[7:0], i_rx_data.cmd.mask[15:8]};

    // A 16-bit access must fit in the bank
    assign ro_hit = !bank_rw && (byte_off <= 15'(RO_BYTES - 2));
    assign rw_hit =  bank_rw && (byte_off <= 15'(RW_BYTES - 2));
    assign ro_bit = {byte_off[RO_AW-1:0], 3'b000};
    assign rw_bit = {byte_off[RW_AW-1:0], 3'b000};

    assign rd_word = ro_hit ? RO_IMAGE[ro_bit +: 16] :
                     rw_hit ? rw_q[rw_bit +: 16]     : 16'h0000;  // Zero outside a bank

    // Masked merge
    assign rw_old = rw_q[rw_bit +: 16];
    assign rw_new = (rw_old & ~cmd_mask) | (cmd_value & cmd_mask);

    assign do_read  = is_cmd && i_rx_data.cmd.rd;
    assign do_write = is_cmd && i_rx_data.cmd.wr && rw_hit;     // RO bank never written

    // ----------------------------------------------------------
    // Send counter
    // ----------------------------------------------------------
    logic [15:0] send_count;
    logic        send_en;
    logic        do_count;

    assign send_count = rw_q[RW_ADDR_COUNT*8 +: 16];
    assign send_en    = rw_q[RW_ADDR_CTRL*8 + CTRL_SEND_EN];
    assign do_count   = !do_read && !do_write && !resp_q.almost_full &&
                        send_en && (send_count != 16'h0000);   // Lowest priority

    // Control state and register file
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            loop_q.wr_en <= 1'b0;
            resp_q.wr_en <= 1'b0;
            rw_q         <= RW_RESET;                   // Magic back, counter disarmed
        end
        else
        begin
            loop_q.wr_en <= is_loop;
            resp_q.wr_en <= do_read || do_count;
            if (do_write)
                rw_q[rw_bit +: 16] <= rw_new;
            else if (do_count)
                rw_q[RW_ADDR_COUNT*8 +: 16] <= send_count - 16'd1;  // Count down
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        loop_q.wr_data.ctx  <= i_rx_data.loop.ctx;
        loop_q.wr_data.data <= i_rx_data.loop.payload;
        resp_q.wr_data.ctx  <= 2'b00;
        if (do_read)
            resp_q.wr_data.data <= {cmd_addr, rd_word[7:0], rd_word[15:8]};  // Swapped back
        else
            resp_q.wr_data.data <= {COUNT_TAG_ADDR, send_count};
    end

endmodule

//--- design/sync_fifo.sv
// Single clock show-ahead buffer of FIFO_DEPTH entries. Writes while full are dropped
`timescale 1ns/100ps

module sync_fifo
    import proto_pkg::*;
    import regmap_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    fifo_if.buffer q
);

    // ----------------------------------------------------------
    // Storage and pointers
    // ----------------------------------------------------------
    fifo_entry_t           store [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;          // Wraps at depth
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   fill;            // One bit wider to reach full
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full = (fill == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign push = q.wr_en && !full;         // Entry lost when full
    assign pop  = q.rd_en && q.rd_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (FIFO_PTR_W+1)'(push) - (FIFO_PTR_W+1)'(pop);
        end
    end

    // Memory write port
    always_ff @(posedge clk)
    begin
        if (push)
            store[wr_ptr] <= q.wr_data;
    end

    // Head shown directly
    assign q.rd_data     = store[rd_ptr];
    assign q.rd_valid    = (fill != '0);
    assign q.almost_full = (fill >= (FIFO_PTR_W+1)'(FIFO_AFULL));  // Producer slack

endmodule

//--- design/tx_arbiter.sv
// Fixed priority with loopback first. A busy loopback stream can starve responses
`timescale 1ns/100ps

module tx_arbiter
    import proto_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    fifo_if.consumer    loop_q,
    fifo_if.consumer    resp_q,
    output logic [31:0] o_tx_data,
    output tx_tag_t     o_tx_tag,
    output logic [1:0]  o_tx_ctx,
    output logic        o_tx_valid,
    input  logic        i_tx_ready
);

    // ----------------------------------------------------------
    // Selection
    // ----------------------------------------------------------
    logic        load_ok;                   // Output register free this cycle
    logic        pop_any;
    fifo_entry_t pick;

    assign load_ok = !o_tx_valid || i_tx_ready;
    assign pop_any = load_ok && (loop_q.rd_valid || resp_q.rd_valid);
    assign pick    = loop_q.rd_valid ? loop_q.rd_data : resp_q.rd_data;

    assign loop_q.rd_en = load_ok && loop_q.rd_valid;
    assign resp_q.rd_en = load_ok && !loop_q.rd_valid && resp_q.rd_valid;  // Only if loop idle

    // Valid and tag
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_tx_valid <= 1'b0;
            o_tx_tag   <= TAG_LOOP;
        end
        else if (load_ok)
        begin
            o_tx_valid <= pop_any;
            if (pop_any)
                o_tx_tag <= loop_q.rd_valid ? TAG_LOOP : TAG_RESP;
        end
    end

    // Payload held while stalled
    always_ff @(posedge clk)
    begin
        if (pop_any)
        begin
            o_tx_data <= pick.data;
            o_tx_ctx  <= pick.ctx;
        end
    end

endmodule

//--- design/fifo_ctl_top.sv
// Input has no back-pressure. Output transfers when o_tx_valid and i_tx_ready are both high
`timescale 1ns/100ps

module fifo_ctl_top
(
    input  logic        clk,
    input  logic        rst,
    input  logic [63:0] i_rx_data,          // Host word
    input  logic        i_rx_valid,
    output logic [31:0] o_tx_data,
    output logic [1:0]  o_tx_tag,           // 2'b10 loopback, 2'b11 response
    output logic [1:0]  o_tx_ctx,
    output logic        o_tx_valid,
    input  logic        i_tx_ready
);

    // ----------------------------------------------------------
    // Buffers between engine and arbiter
    // ----------------------------------------------------------
    fifo_if loop_q ();
    fifo_if resp_q ();

    cmd_engine u_cmd_engine (
        .clk        (clk),
        .rst        (rst),
        .i_rx_data  (i_rx_data),
        .i_rx_valid (i_rx_valid),
        .loop_q     (loop_q.producer),
        .resp_q     (resp_q.producer)
    );

    sync_fifo u_loop_fifo (
        .clk (clk),
        .rst (rst),
        .q   (loop_q.buffer)
    );

    sync_fifo u_resp_fifo (
        .clk (clk),
        .rst (rst),
        .q   (resp_q.buffer)
    );

    // Output mux and register
    tx_arbiter u_tx_arbiter (
        .clk        (clk),
        .rst        (rst),
        .loop_q     (loop_q.consumer),
        .resp_q     (resp_q.consumer),
        .o_tx_data  (o_tx_data),
        .o_tx_tag   (o_tx_tag),
        .o_tx_ctx   (o_tx_ctx),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready)
    );

endmodule

//--- test/fifo_ctl_asserts.sv
// Output protocol checks only. Bound into every fifo_ctl_top instance
`timescale 1ns/100ps

module fifo_ctl_asserts
(
    input logic        clk,
    input logic        rst,
    input logic [31:0] i_tx_data,
    input logic [1:0]  i_tx_tag,
    input logic [1:0]  i_tx_ctx,
    input logic        i_tx_valid,
    input logic        i_tx_ready
);

    // Synchronous reset clears valid
    a_reset_idle: assert property (@(posedge clk) rst |=> !i_tx_valid)
        else $error("o_tx_valid high after reset");

    // ----------------------------------------------------------
    // Stall holds the word
    // ----------------------------------------------------------
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data) &&
                                         $stable(i_tx_tag) && $stable(i_tx_ctx)))
        else $error("Output word changed while stalled");

    a_tag: assert property (@(posedge clk) disable iff (rst)
        i_tx_valid |-> (i_tx_tag == 2'b10 || i_tx_tag == 2'b11))     // Loop or response
        else $error("Output tag out of range");

endmodule

bind fifo_ctl_top fifo_ctl_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .i_tx_data  (o_tx_data),
    .i_tx_tag   (o_tx_tag),
    .i_tx_ctx   (o_tx_ctx),
    .i_tx_valid (o_tx_valid),
    .i_tx_ready (i_tx_ready)
);

//--- test/tb_fifo_ctl.sv
// Table driven with random ready. Table gaps keep both buffers well below almost full
`timescale 1ns/100ps

module tb_fifo_ctl
    import proto_pkg::*;
    import regmap_pkg::*;
();

    logic        clk;
    logic        rst;
    logic [63:0] i_rx_data;
    logic        i_rx_valid;
    logic [31:0] o_tx_data;
    logic [1:0]  o_tx_tag;
    logic [1:0]  o_tx_ctx;
    logic        o_tx_valid;
    logic        i_tx_ready;

    // One table row, resp is {ctx, data}
    typedef struct packed {
        logic        vld;
        logic [63:0] word;
        logic        exp;
        tx_tag_t     tag;
        logic [33:0] resp;
    } row_t;

    row_t        rows[$];
    logic [33:0] exp_loop[$];       // Expected loopback words in order
    logic [33:0] exp_resp[$];       // Expected reads and count words
    logic [31:0] lcg_state = 32'd83318;
    int          watchdog_cycles = 0;

    fifo_ctl_top uut (
        .clk        (clk),
        .rst        (rst),
        .i_rx_data  (i_rx_data),
        .i_rx_valid (i_rx_valid),
        .o_tx_data  (o_tx_data),
        .o_tx_tag   (o_tx_tag),
        .o_tx_ctx   (o_tx_ctx),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready)
    );

    always #5 clk = ~clk;   // 10 ns period

    // ----------------------------------------------------------
    // Word builders and reference rules
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] swap16(input logic [15:0] v);
        return {v[7:0], v[15:8]};
    endfunction

    function automatic rx_word_u loop_word(input logic [7:0] magic, input rx_type_t rtype,
                                           input logic [1:0] ctx, input logic [31:0] payload);
        rx_word_u w;
        w               = '0;
        w.loop.magic    = magic;
        w.loop.rtype    = rtype;
        w.loop.ctx      = ctx;
        w.loop.payload  = payload;
        return w;
    endfunction

    function automatic rx_word_u cmd_word(input logic rd, input logic wr, input logic [15:0] addr,
                                          input logic [15:0] mask, input logic [15:0] value);
        rx_word_u w;
        w           = '0;
        w.cmd.magic = HOST_MAGIC;
        w.cmd.rtype = RX_CMD;
        w.cmd.rd    = rd;
        w.cmd.wr    = wr;
        w.cmd.addr  = addr;
        w.cmd.mask  = swap16(mask);     // Host sends both byte-swapped
        w.cmd.value = swap16(value);
        return w;
    endfunction

    task automatic add_gap();
        rows.push_back({1'b0, 64'h0, 1'b0, TAG_LOOP, 34'h0});   // Idle cycle
    endtask

    task automatic add_loop(input logic [1:0] ctx, input logic [31:0] payload);
        rows.push_back({1'b1, 64'(loop_word(HOST_MAGIC, RX_LOOP, ctx, payload)), 1'b1,
                        TAG_LOOP, {ctx, payload}});
        add_gap();
    endtask

    task automatic add_read(input logic [15:0] addr, input logic [15:0] val);
        rows.push_back({1'b1, 64'(cmd_word(1'b1, 1'b0, addr, 16'h0, 16'h0)), 1'b1,
                        TAG_RESP, {2'b00, addr, swap16(val)}});   // Address high, value low
        add_gap();
    endtask

    task automatic add_write(input logic [15:0] addr, input logic [15:0] mask,
                             input logic [15:0] val);
        rows.push_back({1'b1, 64'(cmd_word(1'b0, 1'b1, addr, mask, val)), 1'b0,
                        TAG_RESP, 34'h0});
        add_gap();
    endtask

    task automatic add_drop(input rx_word_u w);
        rows.push_back({1'b1, 64'(w), 1'b0, TAG_LOOP, 34'h0});  // Must vanish
        add_gap();
    endtask

    task automatic add_count(input logic [15:0] v);
        rows.push_back({1'b0, 64'h0, 1'b1, TAG_RESP, {2'b00, COUNT_TAG_ADDR, v}});
    endtask

    // ----------------------------------------------------------
    // Checking
    // ----------------------------------------------------------
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic abort(input string why);
        $display("%s at %0d ns", why, $time);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic take_output();
        logic [33:0] exp;
        if (o_tx_tag == TAG_LOOP && exp_loop.size() != 0)
            exp = exp_loop.pop_front();
        else if (o_tx_tag == TAG_RESP && exp_resp.size() != 0)
            exp = exp_resp.pop_front();
        else
            abort("Output word arrived with no matching expected word");
        check("o_tx_data", o_tx_data, exp[31:0]);
        check("o_tx_ctx", {30'h0, o_tx_ctx}, {30'h0, exp[33:32]});
    endtask

    // Transfer on valid and ready
    always @(posedge clk)
    begin
        if (!rst && o_tx_valid && i_tx_ready)
            take_output();
    end

    // Random back-pressure, about one cycle in four stalled
    always @(posedge clk)
    begin
        lcg_state = lcg_next(lcg_state);
        i_tx_ready <= (lcg_state[16:15] != 2'b00);
    end

    initial
    begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort("Timeout: expected output words still missing");
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        i_rx_data  = '0;
        i_rx_valid = 1'b0;
        i_tx_ready = 1'b0;

        for (int i = 0; i < 6; i++)
            add_loop(2'(i), 32'h10000000 + i * 32'h01010101);   // Plain loopback stream
        add_read(16'h0000, RO_MAGIC);
        add_read(16'h0004, 16'(RO_BYTES));
        add_read(16'h0008, {VERSION_MINOR, VERSION_MAJOR});     // Major in low byte
        add_read(16'h000a, {8'h00, DEVICE_ID});
        add_read(16'h000c, CUSTOM_VALUE[15:0]);
        add_read(16'h000e, CUSTOM_VALUE[31:16]);
        add_read(16'h0010, 16'h0000);                           // Past the RO bank
        add_read(16'h8000, RW_MAGIC);
        add_write(16'h8006, 16'h00ff, 16'h1234);
        add_read(16'h8006, 16'h0034);
        add_write(16'h8006, 16'hf0f0, 16'habcd);
        add_read(16'h8006, 16'ha0c4);                           // High nibbles from abcd
        add_write(16'h0000, 16'hffff, 16'h5555);                // RO bank ignores it
        add_read(16'h0000, RO_MAGIC);
        add_drop(loop_word(8'h55, RX_LOOP, 2'b01, 32'hdeadbeef));
        add_drop(loop_word(HOST_MAGIC, RX_TLP, 2'b01, 32'hdeadbeef));
        add_drop(loop_word(HOST_MAGIC, RX_CFG, 2'b10, 32'hdeadbeef));
        add_loop(2'b11, 32'h600dcafe);
        add_write(16'h8000 + 16'(RW_ADDR_COUNT), 16'hffff, 16'h0003);
        add_write(16'h8000 + 16'(RW_ADDR_CTRL), 16'h0001, 16'h0001);    // Arm
        for (int n = 3; n > 0; n--)
            add_count(16'(n));
        for (int g = 0; g < 6; g++)
            add_gap();
        add_read(16'h8000 + 16'(RW_ADDR_COUNT), 16'h0000);      // Counted out
        watchdog_cycles = rows.size() * 4 + 200;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        foreach (rows[i])
        begin
            @(posedge clk);
            i_rx_valid <= rows[i].vld;
            i_rx_data  <= rows[i].word;
            if (rows[i].exp && rows[i].tag == TAG_LOOP)
                exp_loop.push_back(rows[i].resp);
            else if (rows[i].exp)
                exp_resp.push_back(rows[i].resp);
        end
        @(posedge clk);
        i_rx_valid <= 1'b0;

        while (exp_loop.size() != 0 || exp_resp.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);     // Room for stray words

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- filelist.f
design/proto_pkg.sv
design/regmap_pkg.sv
design/fifo_if.sv
design/cmd_engine.sv
design/sync_fifo.sv
design/tx_arbiter.sv
design/fifo_ctl_top.sv
test/fifo_ctl_asserts.sv
test/tb_fifo_ctl.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fifo_ctl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_fifo_ctl -f filelist.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_fifo_ctl > sim.log 2>&1 ; cat sim.log

grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
